// ==== Bender.yml ====
package:
  name: thor_ifetch

sources:
  - files:
      - rtl/thor_ifetch_pkg.sv
      - rtl/thor_inslength.sv
      - rtl/thor_ins_align.sv
      - rtl/thor_fetch_ctrl.sv
      - rtl/thor_ifetch.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/thor_ifetch_checker.sv
      - verification/tb_thor_ifetch.sv

// ==== rtl/thor_fetch_ctrl.sv ====
// Fetch controller
// Sequences aligned fetch addresses, issues one request at a time and
// drops responses made stale by a redirect

`timescale 1ns/100ps

module thor_fetch_ctrl (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    redirect,
  input  logic [thor_ifetch_pkg::addr_w-1:0]      redirect_pc,
  input  logic                                    room,
  output logic                                    fetch_req,
  output logic [thor_ifetch_pkg::addr_w-1:0]      fetch_addr,
  input  logic                                    fetch_valid,
  input  thor_ifetch_pkg::fetch_rsp_t             fetch_rsp,
  output logic                                    word_valid,
  output thor_ifetch_pkg::fetch_rsp_t             word_rsp,
  output logic [thor_ifetch_pkg::fetch_off_w-1:0] skip_bytes
);

  import thor_ifetch_pkg::*;

  // Aligned address of the next word to request
  logic [addr_w-1:0]      next_addr;
  // A request is out and its response has not come back
  logic                   outstanding;
  // The outstanding response belongs to the stream before a redirect
  logic                   stale;
  // Offset of the redirect target inside the first word after it
  logic                   skip_pending;
  logic [fetch_off_w-1:0] skip_val;

  // ========================================
  // Response path
  // ========================================

  // Responses go straight through in the cycle they arrive
  // A redirect in the arrival cycle also kills the word
  assign word_valid = fetch_valid && !stale && !redirect;
  assign word_rsp   = fetch_rsp;
  assign skip_bytes = skip_pending ? skip_val : '0;

  // ========================================
  // Request sequencing
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      next_addr    <= '0;
      outstanding  <= 1'b0;
      stale        <= 1'b0;
      fetch_req    <= 1'b0;
      skip_pending <= 1'b0;
      skip_val     <= '0;
    end else begin
      fetch_req <= 1'b0;

      // The response closes the outstanding request, stale or not
      if (fetch_valid)
        outstanding <= 1'b0;

      if (redirect) begin
        // Restart at the word holding the target and remember the offset
        next_addr    <= {redirect_pc[addr_w-1:fetch_off_w], {fetch_off_w{1'b0}}};
        skip_pending <= 1'b1;
        skip_val     <= redirect_pc[fetch_off_w-1:0];
        stale        <= outstanding && !fetch_valid;
      end else begin
        if (fetch_valid)
          stale <= 1'b0;
        if (word_valid)
          skip_pending <= 1'b0;
        // No new request in the cycle after a redirect
        if (!outstanding && room) begin
          fetch_req   <= 1'b1;
          outstanding <= 1'b1;
          next_addr   <= next_addr + fetch_bytes;
        end
      end
    end
  end

  // The address rides along with the request pulse
  always_ff @(posedge clk) begin
    if (!outstanding && room && !redirect)
      fetch_addr <= next_addr;
  end

  // ========================================
  // Assertions
  // ========================================

  // After a request no other is issued up to and including its response
  a_one_outstanding : assert property (@(posedge clk) disable iff (!rst_n)
    fetch_req |=> (!fetch_req until_with fetch_valid));

endmodule

// ==== rtl/thor_ifetch.sv ====
// Instruction fetch and align front end
// Connects the fetch controller and the aligner to the memory port, the
// redirect input and the instruction output

`timescale 1ns/100ps

module thor_ifetch (
  input  logic                               clk,
  input  logic                               rst_n,
  // Instruction memory port
  output logic                               fetch_req,
  output logic [thor_ifetch_pkg::addr_w-1:0] fetch_addr,
  input  logic                               fetch_valid,
  input  thor_ifetch_pkg::fetch_rsp_t        fetch_rsp,
  // Redirect from the back end
  input  logic                               redirect,
  input  logic [thor_ifetch_pkg::addr_w-1:0] redirect_pc,
  // Aligned instruction stream
  output logic                               ins_valid,
  output thor_ifetch_pkg::ins_t              ins_out
);

  import thor_ifetch_pkg::*;

  // ========================================
  // Internal wires
  // ========================================

  logic                   room;
  logic                   word_valid;
  fetch_rsp_t             word_rsp;
  logic [fetch_off_w-1:0] skip_bytes;

  // Request side and stale response filter
  thor_fetch_ctrl fetch_ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .room        (room),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_valid (fetch_valid),
    .fetch_rsp   (fetch_rsp),
    .word_valid  (word_valid),
    .word_rsp    (word_rsp),
    .skip_bytes  (skip_bytes)
  );

  // Byte queue and instruction output
  thor_ins_align ins_align_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .word_valid  (word_valid),
    .word_rsp    (word_rsp),
    .skip_bytes  (skip_bytes),
    .room        (room),
    .ins_valid   (ins_valid),
    .ins_out     (ins_out)
  );

endmodule

// ==== rtl/thor_ifetch_pkg.sv ====
// Shared definitions for the instruction fetch and align front end
// Holds the opcode set, the size constants and the structs that carry
// fetched words and aligned instructions

package thor_ifetch_pkg;

  // ========================================
  // Sizes
  // ========================================

  // Width of one memory fetch in bytes, fetches are always aligned to it
  localparam int fetch_bytes = 8;
  // Capacity of the aligner byte queue, two fetch words
  localparam int queue_bytes = 16;
  // Instruction address width
  localparam int addr_w = 32;
  // Width of an instruction length in bytes
  localparam int ins_len_w = 4;
  // Longest instruction in bytes
  localparam int max_ins_bytes = 8;
  // Byte offset of an address inside a fetch word
  localparam int fetch_off_w = $clog2(fetch_bytes);
  // Queue byte count, wide enough to hold queue_bytes itself
  localparam int cnt_w = $clog2(queue_bytes) + 1;

  // ========================================
  // Opcodes
  // ========================================

  // Only the opcodes this design names are listed here
  // Any value not listed decodes as a 2 byte instruction, except the
  // branch block 8'h20 to 8'h3F and the indexed memory block 8'hD0 to 8'hEF,
  // which are 6 bytes long
  typedef enum logic [7:0] {
    BRK   = 8'h00,
    R1    = 8'h01,
    R2    = 8'h02,
    ADDI  = 8'h04,
    ANDI  = 8'h08,
    ORI   = 8'h09,
    CSR   = 8'h0F,
    JEQZ  = 8'h1C,
    ADDIL = 8'h44,
    EXI55 = 8'h53,
    LDO   = 8'h86,
    LEA   = 8'h88,
    STO   = 8'h93,
    SYS   = 8'hA5,
    MOV   = 8'hA7,
    NOP   = 8'hF1,
    RTS   = 8'hF2,
    WFI   = 8'hF4,
    PUSH  = 8'hF8,
    POP   = 8'hF9
  } opcode_e;

  // ========================================
  // Structs
  // ========================================

  // One response from instruction memory
  // Byte 0 of data sits at addr, the word is little endian
  typedef struct packed {
    logic [fetch_bytes*8-1:0] data;
    logic [addr_w-1:0]        addr;
  } fetch_rsp_t;

  // One aligned instruction as handed to decode
  // Byte 0 of bits is the opcode and bytes at or above len read as zero
  typedef struct packed {
    logic [addr_w-1:0]          pc;
    logic [ins_len_w-1:0]       len;
    logic [max_ins_bytes*8-1:0] bits;
  } ins_t;

endpackage

// ==== rtl/thor_ins_align.sv ====
// Instruction aligner
// Packs fetched words into a byte queue and emits one whole instruction
// per cycle with its pc and length

`timescale 1ns/100ps

module thor_ins_align (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    redirect,
  input  logic [thor_ifetch_pkg::addr_w-1:0]      redirect_pc,
  input  logic                                    word_valid,
  input  thor_ifetch_pkg::fetch_rsp_t             word_rsp,
  input  logic [thor_ifetch_pkg::fetch_off_w-1:0] skip_bytes,
  output logic                                    room,
  output logic                                    ins_valid,
  output thor_ifetch_pkg::ins_t                   ins_out
);

  import thor_ifetch_pkg::*;

  // ========================================
  // Queue state
  // ========================================

  // Byte 0 is the head of the queue, always an instruction boundary
  logic [queue_bytes-1:0][7:0] q;
  logic [queue_bytes-1:0][7:0] q_next;
  logic [queue_bytes-1:0][7:0] q_shift;
  logic [cnt_w-1:0]            count;
  logic [cnt_w-1:0]            count_next;
  // Address of the byte at the head of the queue
  logic [addr_w-1:0]           head_pc;

  logic [ins_len_w-1:0]        len;
  logic                        have_ins;
  logic [cnt_w-1:0]            rem_bytes;
  logic [cnt_w-1:0]            base;
  logic [cnt_w-1:0]            add_bytes;
  ins_t                        ins_next;

  // Length of the instruction at the head, valid once the opcode byte is in
  thor_inslength len_dec (
    .opcode (q[0]),
    .len    (len)
  );

  // A whole instruction sits in the queue once it holds len bytes
  // With count at zero the decoded length is at least 2, so no false hit
  assign have_ins = count >= cnt_w'(len);

  // The next word fits only while at most one word is queued
  assign room = count <= cnt_w'(queue_bytes - fetch_bytes);

  // ========================================
  // Next queue contents
  // ========================================

  always_comb begin
    rem_bytes = have_ins ? cnt_w'(len) : '0;
    base      = count - rem_bytes;
    add_bytes = word_valid ? cnt_w'(fetch_bytes) - cnt_w'(skip_bytes) : '0;

    // Drop the outgoing instruction from the front
    for (int i = 0; i < queue_bytes; i++) begin
      if (i + rem_bytes < queue_bytes)
        q_shift[i] = q[i + rem_bytes];
      else
        q_shift[i] = 8'h00;
    end

    // Append the new word behind the remaining bytes
    // Bytes below skip_bytes come before a redirect target and are dropped
    q_next = q_shift;
    if (word_valid) begin
      for (int j = 0; j < fetch_bytes; j++) begin
        if (j >= skip_bytes && base + j - skip_bytes < queue_bytes)
          q_next[base + j - skip_bytes] = word_rsp.data[8*j +: 8];
      end
    end

    count_next = base + add_bytes;
  end

  // The instruction leaves with its upper bytes cleared
  always_comb begin
    ins_next.pc  = head_pc;
    ins_next.len = len;
    for (int b = 0; b < max_ins_bytes; b++) begin
      if (b < len)
        ins_next.bits[8*b +: 8] = q[b];
      else
        ins_next.bits[8*b +: 8] = 8'h00;
    end
  end

  // ========================================
  // Registers
  // ========================================

  // A redirect flushes the queue but the instruction taken in the same
  // cycle belongs to the old stream and still goes out
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count     <= '0;
      head_pc   <= '0;
      ins_valid <= 1'b0;
    end else begin
      ins_valid <= have_ins;
      if (redirect) begin
        count   <= '0;
        head_pc <= redirect_pc;
      end else begin
        count <= count_next;
        if (have_ins)
          head_pc <= head_pc + len;
      end
    end
  end

  // Queue bytes and the output instruction carry no reset
  always_ff @(posedge clk) begin
    q <= q_next;
    if (have_ins)
      ins_out <= ins_next;
  end

  // ========================================
  // Assertions
  // ========================================

  // The queue never overflows
  a_count_max : assert property (@(posedge clk) disable iff (!rst_n)
    count <= cnt_w'(queue_bytes));

  // The fetch controller only requests a word while there is room for it
  a_word_room : assert property (@(posedge clk) disable iff (!rst_n)
    word_valid |-> room);

  // The arriving word continues the queued bytes without a gap
  a_word_contig : assert property (@(posedge clk) disable iff (!rst_n)
    word_valid |-> head_pc + count == word_rsp.addr + skip_bytes);

endmodule

// ==== rtl/thor_inslength.sv ====
// Instruction length decoder
// Maps the opcode byte onto the instruction length in bytes, purely
// combinational

`timescale 1ns/100ps

module thor_inslength (
  input  logic [7:0]                            opcode,
  output logic [thor_ifetch_pkg::ins_len_w-1:0] len
);

  import thor_ifetch_pkg::*;

  // Opcode viewed through the enum so the table reads by name
  opcode_e op;

  assign op = opcode_e'(opcode);

  // The table below is the length rule for the whole front end
  // Wildcard items cover the two opcode blocks that share one length
  always_comb begin
    casez (op)
      // Short forms, register only or no operands at all
      BRK,
      NOP,
      RTS,
      PUSH,
      POP,
      WFI:      len = 4'd2;

      // Forms with a short immediate or a short displacement
      R1,
      ADDI,
      ANDI,
      ORI,
      MOV,
      SYS,
      JEQZ:     len = 4'd4;

      // Three register forms, long immediates and memory ops
      R2,
      CSR,
      ADDIL,
      LDO,
      STO,
      LEA:      len = 4'd6;

      // Conditional branches
      8'h2?:    len = 4'd6;
      // Decrement and branch group
      8'h3?:    len = 4'd6;

      // Indexed loads and stores
      8'hD?:    len = 4'd6;
      8'hE?:    len = 4'd6;

      // The long immediate extension carries a full 55 bit constant
      EXI55:    len = 4'd8;

      // Anything not named is treated as a short form
      default:  len = 4'd2;
    endcase
  end

endmodule

// ==== thor_ifetch.f ====
+incdir+verification
rtl/thor_ifetch_pkg.sv
rtl/thor_inslength.sv
rtl/thor_ins_align.sv
rtl/thor_fetch_ctrl.sv
rtl/thor_ifetch.sv
verification/thor_ifetch_checker.sv
verification/tb_thor_ifetch.sv

// ==== verification/prog_image.svh ====
// Program image and random bit source for the testbench modules
// Every image byte is a fixed function of its full address, so the memory
// model and the checker see the same program

localparam logic [31:0] lfsr_seed = 32'h722d_79f0;

// One step of a Galois LFSR for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0])
    return (s >> 1) ^ 32'h8020_0003;
  else
    return s >> 1;
endfunction

// Byte of the program image at one address
function automatic logic [7:0] image_byte(input logic [31:0] addr);
  logic [31:0] s;
  logic [11:0] raw;
  int          i;
  s = lfsr_seed ^ addr ^ {addr[15:0], addr[31:16]};
  // Warm up so that neighbouring addresses drift apart
  for (i = 0; i < 32; i++)
    s = lfsr_next(s);
  for (i = 0; i < 12; i++) begin
    raw[i] = s[0];
    s      = lfsr_next(s);
  end
  // Extra EXI55 opcodes so the 8 byte form turns up often enough
  if (raw[11:8] == 4'h0)
    return EXI55;
  else
    return raw[7:0];
endfunction

// ==== verification/tb_thor_ifetch.sv ====
// Testbench for the instruction fetch and align front end
// Drives a memory model with random latency and random redirects, and
// leaves the comparing to the stream checker

`timescale 1ns/100ps

module tb_thor_ifetch;

  import thor_ifetch_pkg::*;
  `include "prog_image.svh"

  localparam int target_ins   = 2000;
  localparam int run_limit    = 200000;
  localparam int report_limit = 100;

  logic              clk;
  logic              rst_n;
  logic              fetch_req;
  logic [addr_w-1:0] fetch_addr;
  logic              fetch_valid;
  fetch_rsp_t        fetch_rsp;
  logic              redirect;
  logic [addr_w-1:0] redirect_pc;
  logic              ins_valid;
  ins_t              ins_out;

  logic              report;
  int                ins_count;
  int                tests_run;
  int                tests_failed;
  logic              reported;

  logic [31:0]       rnd_state;
  logic [31:0]       tmp;
  logic              mem_busy;
  int                mem_wait;
  logic [addr_w-1:0] mem_addr;
  int                quiet;
  int                waited;
  logic              timed_out;

  thor_ifetch thor_ifetch_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_valid (fetch_valid),
    .fetch_rsp   (fetch_rsp),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .ins_valid   (ins_valid),
    .ins_out     (ins_out)
  );

  thor_ifetch_checker checker_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .fetch_valid  (fetch_valid),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .ins_valid    (ins_valid),
    .ins_out      (ins_out),
    .report       (report),
    .ins_count    (ins_count),
    .tests_run    (tests_run),
    .tests_failed (tests_failed),
    .reported     (reported)
  );

  always #20 clk = ~clk;

  // Takes n random bits with one LFSR step for each bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v[i]      = rnd_state[0];
      rnd_state = lfsr_next(rnd_state);
    end
    return v;
  endfunction

  function automatic fetch_rsp_t read_word(input logic [addr_w-1:0] addr);
    fetch_rsp_t r;
    int         k;
    r.addr = addr;
    for (k = 0; k < fetch_bytes; k++)
      r.data[8*k +: 8] = image_byte(addr + k);
    return r;
  endfunction

  // ========================================
  // Memory model and redirects
  // ========================================

  // Latency and redirect draws come from one LFSR stream in a fixed order
  always @(posedge clk) begin
    fetch_valid <= 1'b0;
    redirect    <= 1'b0;
    if (fetch_req) begin
      mem_busy = 1'b1;
      mem_addr = fetch_addr;
      mem_wait = 1 + take_bits(4) % 15;
    end
    if (mem_busy) begin
      mem_wait--;
      if (mem_wait == 0) begin
        fetch_valid <= 1'b1;
        fetch_rsp   <= read_word(mem_addr);
        mem_busy = 1'b0;
      end
    end
    // Redirects start once the reset stream has been seen for a while
    if (ins_count >= 50) begin
      if (quiet > 0) begin
        quiet--;
      end else if (take_bits(5) == 0) begin
        tmp = take_bits(15);
        redirect    <= 1'b1;
        redirect_pc <= {{(addr_w-16){1'b0}}, tmp[14:0], 1'b0};
        quiet = 12;
      end
    end
  end

  // ========================================
  // Sequence and final report
  // ========================================

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    fetch_valid = 1'b0;
    fetch_rsp = '0;
    redirect = 1'b0;
    redirect_pc = '0;
    report = 1'b0;
    rnd_state = lfsr_seed;
    tmp = '0;
    mem_busy = 1'b0;
    mem_wait = 0;
    mem_addr = '0;
    quiet = 0;
    timed_out = 1'b0;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    waited = 0;
    while (ins_count < target_ins && waited < run_limit) begin
      @(posedge clk);
      waited++;
    end
    if (ins_count < target_ins) begin
      $display("Timeout: only %0d of %0d instructions arrived in %0d cycles",
               ins_count, target_ins, run_limit);
      timed_out = 1'b1;
    end else begin
      report <= 1'b1;
      waited = 0;
      while (!reported && waited < report_limit) begin
        @(posedge clk);
        waited++;
      end
      if (!reported) begin
        $display("Timeout: the checker did not deliver its report");
        timed_out = 1'b1;
      end else begin
        $display("Tests run %0d, passed %0d, failed %0d, instructions %0d",
                 tests_run, tests_run - tests_failed, tests_failed, ins_count);
      end
    end

    if (!timed_out && tests_failed == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== verification/thor_ifetch_checker.sv ====
// Instruction stream checker
// Walks the program image with its own length rule and compares every
// emitted instruction, and watches the memory port protocol

`timescale 1ns/100ps

module thor_ifetch_checker (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               fetch_req,
  input  logic [thor_ifetch_pkg::addr_w-1:0] fetch_addr,
  input  logic                               fetch_valid,
  input  logic                               redirect,
  input  logic [thor_ifetch_pkg::addr_w-1:0] redirect_pc,
  input  logic                               ins_valid,
  input  thor_ifetch_pkg::ins_t              ins_out,
  input  logic                               report,
  output int                                 ins_count,
  output int                                 tests_run,
  output int                                 tests_failed,
  output logic                               reported
);

  import thor_ifetch_pkg::*;
  `include "prog_image.svh"

  localparam int n_tests = 6;
  localparam int t_reset = 0;
  localparam int t_pc    = 1;
  localparam int t_len   = 2;
  localparam int t_bits  = 3;
  localparam int t_redir = 4;
  localparam int t_proto = 5;

  // Per test check and error counts
  int                checks [n_tests];
  int                errs [n_tests];
  // Instructions seen for each length in bytes
  int                len_hits [9];
  int                count;
  int                stale_redirects;
  int                branch_hits;
  int                indexed_hits;
  int                default_hits;
  int                failed;
  // Address of the next instruction in the model stream
  logic [addr_w-1:0] exp_pc;
  logic [addr_w-1:0] pend_pc;
  logic              pend_apply;
  logic              first_after;
  logic              seen_any;
  logic              req_open;
  // Address the next memory request should carry
  logic [addr_w-1:0] exp_fetch;
  logic              redir_last;

  function automatic string test_name(input int t);
    case (t)
      t_reset: return "reset_start";
      t_pc:    return "pc_sequence";
      t_len:   return "length_rule";
      t_bits:  return "bits_match";
      t_redir: return "redirect_target";
      default: return "fetch_protocol";
    endcase
  endfunction

  // Length rule of the instruction set by opcode group
  function automatic int rule_len(input logic [7:0] op);
    if (op == EXI55)
      return 8;
    if (op inside {R1, ADDI, ANDI, ORI, MOV, SYS, JEQZ})
      return 4;
    if (op inside {R2, CSR, ADDIL, LDO, STO, LEA})
      return 6;
    if ((op >= 8'h20 && op <= 8'h3F) || (op >= 8'hD0 && op <= 8'hEF))
      return 6;
    return 2;
  endfunction

  task automatic value_error(input int t, input logic [63:0] exp, input logic [63:0] act);
    errs[t]++;
    $display("[ERROR] %s expected %h actual %h", test_name(t), exp, act);
  endtask

  task automatic plain_error(input int t, input string what);
    errs[t]++;
    $display("%s failed: %s", test_name(t), what);
  endtask

  // ========================================
  // Instruction compare
  // ========================================

  task automatic check_ins();
    logic [7:0]  op;
    logic [63:0] exp_bits;
    int          len;
    int          t;
    int          b;
    op  = image_byte(exp_pc);
    len = rule_len(op);
    count++;
    // The first instruction of a stream is scored by what started it
    if (!seen_any)
      t = t_reset;
    else if (first_after)
      t = t_redir;
    else
      t = t_pc;
    checks[t]++;
    if (ins_out.pc !== exp_pc)
      value_error(t, exp_pc, ins_out.pc);
    checks[t_len]++;
    if (ins_out.len !== ins_len_w'(len))
      value_error(t_len, len, ins_out.len);
    // Bytes past the instruction must read as zero
    exp_bits = '0;
    for (b = 0; b < len; b++)
      exp_bits[8*b +: 8] = image_byte(exp_pc + b);
    checks[t_bits]++;
    if (ins_out.bits !== exp_bits)
      value_error(t_bits, exp_bits, ins_out.bits);
    // Tally which parts of the length table the stream reached
    len_hits[len]++;
    if (op >= 8'h20 && op <= 8'h3F)
      branch_hits++;
    if (op >= 8'hD0 && op <= 8'hEF)
      indexed_hits++;
    if (len == 2 && !(op inside {BRK, NOP, RTS, PUSH, POP, WFI}))
      default_hits++;
    seen_any    = 1'b1;
    first_after = 1'b0;
    exp_pc      = exp_pc + len;
  endtask

  // ========================================
  // Monitor
  // ========================================

  always @(posedge clk) begin
    if (!rst_n) begin
      foreach (checks[i]) begin
        checks[i] = 0;
        errs[i]   = 0;
      end
      foreach (len_hits[i])
        len_hits[i] = 0;
      count = 0;
      stale_redirects = 0;
      branch_hits = 0;
      indexed_hits = 0;
      default_hits = 0;
      exp_pc = '0;
      pend_pc = '0;
      pend_apply = 1'b0;
      first_after = 1'b0;
      seen_any = 1'b0;
      req_open = 1'b0;
      exp_fetch = '0;
      redir_last = 1'b0;
      ins_count <= 0;
      tests_run <= 0;
      tests_failed <= 0;
      reported <= 1'b0;
    end else begin
      // The memory port allows one open request at a time
      if (fetch_valid) begin
        if (!req_open)
          plain_error(t_proto, "fetch_valid arrived with no request open");
        req_open = 1'b0;
      end
      if (fetch_req) begin
        checks[t_proto]++;
        if (req_open)
          plain_error(t_proto, "fetch_req pulsed again before fetch_valid");
        if (redir_last)
          plain_error(t_proto, "fetch_req rose in the cycle after a redirect");
        // Requests walk the image one aligned word at a time
        if (fetch_addr !== exp_fetch)
          value_error(t_proto, exp_fetch, fetch_addr);
        exp_fetch = exp_fetch + fetch_bytes;
        req_open = 1'b1;
      end

      // The instruction one cycle after a redirect still belongs to the old stream
      if (ins_valid)
        check_ins();
      if (pend_apply) begin
        exp_pc      = pend_pc;
        pend_apply  = 1'b0;
        first_after = 1'b1;
      end
      if (redirect) begin
        pend_pc    = redirect_pc;
        pend_apply = 1'b1;
        // Fetch restarts at the word that holds the target
        exp_fetch  = redirect_pc - redirect_pc % fetch_bytes;
        if (req_open)
          stale_redirects++;
      end
      redir_last = redirect;
      ins_count <= count;

      if (report && !reported) begin
        if (len_hits[2] == 0 || len_hits[4] == 0 || len_hits[6] == 0 || len_hits[8] == 0)
          plain_error(t_len, "not every instruction length was seen");
        if (branch_hits == 0 || indexed_hits == 0 || default_hits == 0)
          plain_error(t_len, "branch, indexed or unnamed opcodes were never seen");
        if (stale_redirects == 0)
          plain_error(t_redir, "no redirect arrived while a request was outstanding");
        failed = 0;
        for (int t = 0; t < n_tests; t++) begin
          if (errs[t] == 0) begin
            $display("[PASS] %s: %0d checks", test_name(t), checks[t]);
          end else begin
            $display("[FAIL] %s: %0d checks, %0d errors", test_name(t), checks[t], errs[t]);
            failed++;
          end
        end
        tests_run    <= n_tests;
        tests_failed <= failed;
        reported     <= 1'b1;
      end
    end
  end

endmodule
